/* pool_pkg.sv */
`default_nettype none

package pool_pkg;

	//////////////////////////////////////////////////
	// Image geometry
	//////////////////////////////////////////////////
	localparam int POOL_IMG_W = 16;
	localparam int POOL_IMG_H = 16;
	localparam int POOL_PXL_W = 8;
	localparam int POOL_SUM_W = 12;
	localparam int POOL_FRAME_PIX = POOL_IMG_W * POOL_IMG_H;
	// One row plus one pixel pushes the last centre out
	localparam int POOL_FLUSH_BEATS = POOL_IMG_W + 1;
	localparam int POOL_FIFO_AW = 8;

	// Index and counter widths
	localparam int POOL_COL_W = $clog2(POOL_IMG_W);
	localparam int POOL_ROW_W = $clog2(POOL_IMG_H);
	localparam int POOL_BEAT_W = $clog2(POOL_FRAME_PIX + POOL_FLUSH_BEATS);
	localparam int POOL_FLUSH_W = $clog2(POOL_FLUSH_BEATS + 1);

	// Divide by 9 as x * 3641 >> 15, exact for every 12-bit x
	localparam int POOL_DIV9_SHIFT = 15;
	localparam logic [POOL_SUM_W-1:0] POOL_DIV9_MUL = 3641;

	//////////////////////////////////////////////////
	// Types passed between blocks
	//////////////////////////////////////////////////
	typedef logic [POOL_PXL_W-1:0] pxl_t;
	typedef logic [POOL_SUM_W-1:0] sum_t;
	typedef logic [POOL_BEAT_W-1:0] beat_cnt_t;
	typedef logic [POOL_FLUSH_W-1:0] flush_cnt_t;

	// Window centre completed by the current beat
	typedef struct packed {
		logic [POOL_ROW_W-1:0] row;
		logic [POOL_COL_W-1:0] col;
		logic top;
		logic bottom;
		logic left;
		logic right;
		logic center_valid;
	} pos_t;

	typedef struct packed {
		logic valid;
		pxl_t pxl;
	} beat_t;

	// One vertical slice of the window
	typedef struct packed {
		pxl_t top;
		pxl_t middle;
		pxl_t bottom;
	} column_t;

	typedef struct packed {
		pxl_t p00;
		pxl_t p01;
		pxl_t p02;
		pxl_t p10;
		pxl_t p11;
		pxl_t p12;
		pxl_t p20;
		pxl_t p21;
		pxl_t p22;
	} window_t;

	typedef struct packed {
		logic valid;
		pxl_t pxl;
	} result_t;

endpackage

`default_nettype wire

/* pool_frame_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module pool_frame_ctrl (
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_in,
	input  pool_pkg::pxl_t    pxl_in,
	output logic              ready,
	output pool_pkg::beat_t   beat,
	output pool_pkg::pos_t    pos,
	input  logic              fifo_full,
	input  logic              fifo_empty,
	output logic              drain
);

	typedef enum logic [1:0] {
		ST_ACCEPT,
		ST_FLUSH,
		ST_DRAIN
	} state_t;

	state_t                  state;
	pool_pkg::beat_cnt_t     beat_cnt;
	pool_pkg::flush_cnt_t    flush_cnt;
	pool_pkg::beat_cnt_t     ctr_idx;
	logic                    accept;
	logic                    flush_beat;
	logic                    beat_fire;
	logic                    beat_valid;
	pool_pkg::pxl_t          beat_pxl;
	pool_pkg::pos_t          pos_next;

	//////////////////////////////////////////////////
	// Beat generation
	//////////////////////////////////////////////////
	assign ready = (state == ST_ACCEPT);
	assign accept = valid_in & ready;
	assign flush_beat = (state == ST_FLUSH) &&
		(flush_cnt != pool_pkg::flush_cnt_t'(pool_pkg::POOL_FLUSH_BEATS));
	assign beat_fire = accept | flush_beat;

	// Stop reading as soon as the FIFO runs dry
	assign drain = (state == ST_DRAIN) & ~fifo_empty;

	// Centre sits one row and one column behind the beat
	assign ctr_idx = beat_cnt - pool_pkg::beat_cnt_t'(pool_pkg::POOL_IMG_W + 1);

	always_comb begin
		pos_next.row = ctr_idx[pool_pkg::POOL_COL_W +: pool_pkg::POOL_ROW_W];
		pos_next.col = ctr_idx[pool_pkg::POOL_COL_W-1:0];
		pos_next.top = (pos_next.row == '0);
		pos_next.bottom = (pos_next.row == '1);
		pos_next.left = (pos_next.col == '0);
		pos_next.right = (pos_next.col == '1);
		pos_next.center_valid = (beat_cnt >
			pool_pkg::beat_cnt_t'(pool_pkg::POOL_IMG_W));
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_ACCEPT;
			beat_cnt <= '0;
			flush_cnt <= '0;
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= beat_fire;
			if (beat_fire) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
			case (state)
				ST_ACCEPT: begin
					flush_cnt <= '0;
					if (accept && beat_cnt ==
						pool_pkg::beat_cnt_t'(pool_pkg::POOL_FRAME_PIX - 1)) begin
						state <= ST_FLUSH;
					end
				end
				ST_FLUSH: begin
					if (flush_beat) begin
						flush_cnt <= flush_cnt + 1'b1;
					end else if (fifo_full) begin
						state <= ST_DRAIN;
					end
				end
				ST_DRAIN: begin
					// Last entry left the FIFO, open the next frame
					if (fifo_empty) begin
						state <= ST_ACCEPT;
						beat_cnt <= '0;
					end
				end
				default: state <= ST_ACCEPT;
			endcase
		end
	end

	// Flush beats carry zeros
	always_ff @(posedge clk) begin
		beat_pxl <= accept ? pxl_in : '0;
		pos <= pos_next;
	end

	assign beat.valid = beat_valid;
	assign beat.pxl = beat_pxl;

	// Every centre must be in the FIFO before the drain starts
	a_no_beat_in_drain: assert property (@(posedge clk) disable iff (reset)
		(state == ST_DRAIN) |-> !beat_valid);

	a_drain_starts_full: assert property (@(posedge clk) disable iff (reset)
		$rose(drain) |-> fifo_full);

endmodule

`default_nettype wire

/* pool_line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module pool_line_buffer (
	input  logic                 clk,
	input  logic                 reset,
	input  pool_pkg::beat_t      beat_in,
	input  pool_pkg::pos_t       pos_in,
	output pool_pkg::column_t    column,
	output pool_pkg::pos_t       pos_out,
	output logic                 column_valid
);

	// Row delay memories, one and two rows back
	pool_pkg::pxl_t                    row_mem1 [pool_pkg::POOL_IMG_W];
	pool_pkg::pxl_t                    row_mem2 [pool_pkg::POOL_IMG_W];
	logic [pool_pkg::POOL_COL_W-1:0]   col_ptr;

	//////////////////////////////////////////////////
	// Pointer and valid
	//////////////////////////////////////////////////
	// Free running, a full wrap is exactly one row of delay
	always_ff @(posedge clk) begin
		if (reset) begin
			col_ptr <= '0;
			column_valid <= 1'b0;
		end else begin
			column_valid <= beat_in.valid;
			if (beat_in.valid) begin
				col_ptr <= col_ptr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Row memories
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (beat_in.valid) begin
			row_mem1[col_ptr] <= beat_in.pxl;
			row_mem2[col_ptr] <= row_mem1[col_ptr];
		end
	end

	// Column leaves together with the pixels it replaces
	always_ff @(posedge clk) begin
		if (beat_in.valid) begin
			column.top <= row_mem2[col_ptr];
			column.middle <= row_mem1[col_ptr];
			column.bottom <= beat_in.pxl;
		end
	end

	// Position tag follows the beat by the same cycle
	always_ff @(posedge clk) begin
		pos_out <= pos_in;
	end

endmodule

`default_nettype wire

/* pool_window.sv */
`timescale 1ns/100ps
`default_nettype none

module pool_window (
	input  logic                 clk,
	input  logic                 reset,
	input  pool_pkg::column_t    column,
	input  pool_pkg::pos_t       pos_in,
	input  logic                 column_valid,
	output pool_pkg::window_t    window,
	output logic                 window_valid
);

	pool_pkg::column_t   col_l;
	pool_pkg::column_t   col_m;
	pool_pkg::column_t   tap_l;
	pool_pkg::column_t   tap_m;
	pool_pkg::column_t   tap_r;
	logic [pool_pkg::POOL_ROW_W+pool_pkg::POOL_COL_W-1:0] ctr_next;

	//////////////////////////////////////////////////
	// Zero padding
	//////////////////////////////////////////////////
	always_comb begin
		tap_l = pos_in.left ? '0 : col_l;
		tap_m = col_m;
		tap_r = pos_in.right ? '0 : column;
		if (pos_in.top) begin
			tap_l.top = '0;
			tap_m.top = '0;
			tap_r.top = '0;
		end
		if (pos_in.bottom) begin
			tap_l.bottom = '0;
			tap_m.bottom = '0;
			tap_r.bottom = '0;
		end
	end

	//////////////////////////////////////////////////
	// Shift register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (column_valid) begin
			col_l <= col_m;
			col_m <= column;
			window <= '{p00: tap_l.top, p01: tap_m.top, p02: tap_r.top,
				p10: tap_l.middle, p11: tap_m.middle, p12: tap_r.middle,
				p20: tap_l.bottom, p21: tap_m.bottom, p22: tap_r.bottom};
		end
	end

	// Raster index the next valid centre must carry
	always_ff @(posedge clk) begin
		if (reset) begin
			window_valid <= 1'b0;
			ctr_next <= '0;
		end else begin
			window_valid <= column_valid & pos_in.center_valid;
			if (column_valid && pos_in.center_valid) begin
				ctr_next <= {pos_in.row, pos_in.col} + 1'b1;
			end
		end
	end

	// Each advance with a valid centre brings the raster successor of the last one
	a_centre_in_order: assert property (@(posedge clk) disable iff (reset)
		(column_valid && pos_in.center_valid) |-> ({pos_in.row, pos_in.col} == ctr_next));

endmodule

`default_nettype wire

/* pool_avg_core.sv */
`timescale 1ns/100ps
`default_nettype none

module pool_avg_core (
	input  logic                 clk,
	input  logic                 reset,
	input  pool_pkg::window_t    window,
	input  logic                 window_valid,
	output pool_pkg::result_t    result
);

	pool_pkg::sum_t                          sum_top;
	pool_pkg::sum_t                          sum_mid;
	pool_pkg::sum_t                          sum_bot;
	logic                                    sum_valid;
	pool_pkg::sum_t                          total;
	logic [2*pool_pkg::POOL_SUM_W-1:0]       prod;
	logic [pool_pkg::POOL_PXL_W:0]           quot;

	//////////////////////////////////////////////////
	// Stage 1: row sums
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		sum_top <= pool_pkg::sum_t'(window.p00) + pool_pkg::sum_t'(window.p01) +
			pool_pkg::sum_t'(window.p02);
		sum_mid <= pool_pkg::sum_t'(window.p10) + pool_pkg::sum_t'(window.p11) +
			pool_pkg::sum_t'(window.p12);
		sum_bot <= pool_pkg::sum_t'(window.p20) + pool_pkg::sum_t'(window.p21) +
			pool_pkg::sum_t'(window.p22);
	end

	//////////////////////////////////////////////////
	// Stage 2: total, round, divide by 9
	//////////////////////////////////////////////////
	// Adding 4 turns floor into round to nearest
	assign total = sum_top + sum_mid + sum_bot + pool_pkg::sum_t'(4);
	assign prod = {{pool_pkg::POOL_SUM_W{1'b0}}, total} *
		{{pool_pkg::POOL_SUM_W{1'b0}}, pool_pkg::POOL_DIV9_MUL};
	assign quot = prod[pool_pkg::POOL_DIV9_SHIFT +: pool_pkg::POOL_PXL_W + 1];

	always_ff @(posedge clk) begin
		result.pxl <= quot[pool_pkg::POOL_PXL_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sum_valid <= 1'b0;
			result.valid <= 1'b0;
		end else begin
			sum_valid <= window_valid;
			result.valid <= sum_valid;
		end
	end

	// Top bit of the quotient is spare and must stay clear
	a_result_in_range: assert property (@(posedge clk) disable iff (reset)
		sum_valid |-> (quot <= (pool_pkg::POOL_PXL_W + 1)'(255)));

endmodule

`default_nettype wire

/* pool_out_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module pool_out_fifo (
	input  logic                 clk,
	input  logic                 reset,
	input  pool_pkg::result_t    wr,
	input  logic                 rd_en,
	output logic                 full,
	output logic                 empty,
	output pool_pkg::result_t    rd
);

	pool_pkg::pxl_t                        mem [2**pool_pkg::POOL_FIFO_AW];
	logic [pool_pkg::POOL_FIFO_AW-1:0]     wr_ptr;
	logic [pool_pkg::POOL_FIFO_AW-1:0]     rd_ptr;
	logic [pool_pkg::POOL_FIFO_AW:0]       count;
	logic                                  do_rd;

	assign full = count[pool_pkg::POOL_FIFO_AW];
	assign empty = (count == '0);
	assign do_rd = rd_en & ~empty;

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rd.valid <= 1'b0;
		end else begin
			rd.valid <= do_rd;
			if (wr.valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr.valid, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wr.valid) begin
			mem[wr_ptr] <= wr.pxl;
		end
	end

	always_ff @(posedge clk) begin
		if (do_rd) begin
			rd.pxl <= mem[rd_ptr];
		end
	end

	// One frame fits exactly, so the control never overruns it
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		!(wr.valid && full));

	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		!(rd_en && empty));

endmodule

`default_nettype wire

/* avgp_3x3_top.sv */
`timescale 1ns/100ps
`default_nettype none

module avgp_3x3_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_in,
	input  pool_pkg::pxl_t    pxl_in,
	output logic              ready,
	output logic              valid_out,
	output pool_pkg::pxl_t    pxl_out
);

	pool_pkg::beat_t     beat;
	pool_pkg::pos_t      beat_pos;
	pool_pkg::column_t   column;
	pool_pkg::pos_t      column_pos;
	logic                column_valid;
	pool_pkg::window_t   window;
	logic                window_valid;
	pool_pkg::result_t   core_result;
	pool_pkg::result_t   fifo_rd;
	logic                fifo_full;
	logic                fifo_empty;
	logic                drain;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////
	pool_frame_ctrl pool_frame_ctrl_inst (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.pxl_in     (pxl_in),
		.ready      (ready),
		.beat       (beat),
		.pos        (beat_pos),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty),
		.drain      (drain)
	);

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////
	pool_line_buffer pool_line_buffer_inst (
		.clk          (clk),
		.reset        (reset),
		.beat_in      (beat),
		.pos_in       (beat_pos),
		.column       (column),
		.pos_out      (column_pos),
		.column_valid (column_valid)
	);

	pool_window pool_window_inst (
		.clk          (clk),
		.reset        (reset),
		.column       (column),
		.pos_in       (column_pos),
		.column_valid (column_valid),
		.window       (window),
		.window_valid (window_valid)
	);

	pool_avg_core pool_avg_core_inst (
		.clk          (clk),
		.reset        (reset),
		.window       (window),
		.window_valid (window_valid),
		.result       (core_result)
	);

	// Holds a whole frame, released as one burst
	pool_out_fifo pool_out_fifo_inst (
		.clk   (clk),
		.reset (reset),
		.wr    (core_result),
		.rd_en (drain),
		.full  (fifo_full),
		.empty (fifo_empty),
		.rd    (fifo_rd)
	);

	assign valid_out = fifo_rd.valid;
	assign pxl_out = fifo_rd.pxl;

endmodule

`default_nettype wire

/* tb_avgp_3x3.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_avgp_3x3;

	localparam int FRAMES = 4;
	localparam int PIX = pool_pkg::POOL_FRAME_PIX;
	localparam int W = pool_pkg::POOL_IMG_W;
	localparam int H = pool_pkg::POOL_IMG_H;
	localparam int CYCLE_LIMIT = FRAMES * 700 + 200;

	logic              clk;
	logic              reset;
	logic              valid_in;
	pool_pkg::pxl_t    pxl_in;
	logic              ready;
	logic              valid_out;
	pool_pkg::pxl_t    pxl_out;

	// Current frame image and expected outputs of all frames
	pool_pkg::pxl_t    img [PIX];
	pool_pkg::pxl_t    exp_pix [FRAMES*PIX];
	int                acc_cnt = 0;
	int                out_cnt = 0;
	int                cycle_cnt = 0;
	pool_pkg::pxl_t    exp_head;
	pool_pkg::pxl_t    const_ref;
	logic              expect_ready;

	avgp_3x3_top avgp_3x3_top_inst (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.ready     (ready),
		.valid_out (valid_out),
		.pxl_out   (pxl_out)
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic pool_pkg::pxl_t window_average(input int r, input int c);
		int sum;
		sum = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				// Outside the image counts as zero
				if (r + dr >= 0 && r + dr < H && c + dc >= 0 && c + dc < W) begin
					sum += int'(img[(r + dr) * W + c + dc]);
				end
			end
		end
		// floor(sum / 9 + 1/2), halves go up
		return pool_pkg::pxl_t'((2 * sum + 9) / 18);
	endfunction

	// Frame 1 border values, 4, 6 or 9 live pixels of 255
	function automatic pool_pkg::pxl_t const_frame_value(input int idx);
		int edges;
		edges = 0;
		if (idx / W == 0 || idx / W == H - 1) begin
			edges++;
		end
		if (idx % W == 0 || idx % W == W - 1) begin
			edges++;
		end
		case (edges)
			2: return 8'd113;
			1: return 8'd170;
			default: return 8'd255;
		endcase
	endfunction

	function automatic string frame_name(input int frame);
		case (frame)
			0: return "const_255";
			1: return "ramp_gaps";
			2: return "random_gaps";
			3: return "checker_blocked";
			default: return "after_last_frame";
		endcase
	endfunction

	task automatic fill_frame(input int frame);
		for (int i = 0; i < PIX; i++) begin
			case (frame)
				0: img[i] = 8'd255;
				1: img[i] = pool_pkg::pxl_t'(i);
				2: img[i] = pool_pkg::pxl_t'($urandom);
				default: img[i] = (((i / W) + (i % W)) % 2 == 1) ? 8'd255 : 8'd0;
			endcase
		end
	endtask

	task automatic build_expected(input int frame);
		for (int i = 0; i < PIX; i++) begin
			exp_pix[frame * PIX + i] = window_average(i / W, i % W);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	// A pixel counts only when ready was high as it was driven
	task automatic drive_frame(input bit gaps, input bit offer_blocked);
		int idx;
		idx = 0;
		while (idx < PIX) begin
			@(posedge clk);
			#2;
			if (!ready) begin
				// Junk while blocked, never part of any result
				valid_in = offer_blocked;
				pxl_in = pool_pkg::pxl_t'($urandom);
			end else if (gaps && ($urandom % 4 == 0)) begin
				valid_in = 1'b0;
				pxl_in = pool_pkg::pxl_t'($urandom);
			end else begin
				valid_in = 1'b1;
				pxl_in = img[idx];
				idx++;
			end
		end
		@(posedge clk);
		#2;
		valid_in = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		void'($urandom(32'h362f6013));
		reset = 1'b1;
		valid_in = 1'b0;
		pxl_in = '0;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int f = 0; f < FRAMES; f++) begin
			fill_frame(f);
			build_expected(f);
			drive_frame(f == 1 || f == 2, f == 3);
		end
		wait (out_cnt >= FRAMES * PIX);
		repeat (20) @(posedge clk);
		if (out_cnt != FRAMES * PIX || !ready) begin
			report_failure($sformatf("run ended with %0d outputs and ready %0b",
				out_cnt, ready));
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Monitors and checks
	//////////////////////////////////////////////////
	always @(posedge clk) begin
		if (reset) begin
			acc_cnt <= 0;
			out_cnt <= 0;
		end else begin
			if (valid_in && ready) begin
				acc_cnt <= acc_cnt + 1;
			end
			if (valid_out) begin
				out_cnt <= out_cnt + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			report_failure($sformatf("timeout after %0d cycles with %0d of %0d outputs seen",
				cycle_cnt, out_cnt, FRAMES * PIX));
		end
	end

	assign exp_head = (out_cnt < FRAMES * PIX) ? exp_pix[out_cnt] : '0;
	assign const_ref = const_frame_value(out_cnt % PIX);
	// Low from the last accepted pixel of a frame until its burst is out
	assign expect_ready = !(acc_cnt > 0 && acc_cnt % PIX == 0 && out_cnt < acc_cnt);

	a_ready_rule: assert property (@(posedge clk) disable iff (reset)
		ready == expect_ready)
		else report_failure($sformatf("mismatch %s ready expected %0b actual %0b",
			frame_name($sampled(acc_cnt) / PIX), $sampled(expect_ready), $sampled(ready)));

	a_output_after_frame: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> (acc_cnt % PIX == 0) && (out_cnt < acc_cnt))
		else report_failure("valid_out is high while no complete frame is waiting");

	a_burst_no_gap: assert property (@(posedge clk) disable iff (reset)
		(valid_out && (out_cnt % PIX != 0)) |-> $past(valid_out))
		else report_failure("valid_out dropped inside a burst");

	a_burst_length: assert property (@(posedge clk) disable iff (reset)
		(valid_out && (out_cnt % PIX == 0)) |-> !$past(valid_out))
		else report_failure("burst ran past the frame size");

	a_pixel_value: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> pxl_out == exp_head)
		else report_failure($sformatf("mismatch %s pixel %0d expected %0d actual %0d",
			frame_name($sampled(out_cnt) / PIX), $sampled(out_cnt) % PIX,
			$sampled(exp_head), $sampled(pxl_out)));

	a_const_border: assert property (@(posedge clk) disable iff (reset)
		(valid_out && out_cnt < PIX) |-> pxl_out == const_ref)
		else report_failure($sformatf("mismatch %s border pixel %0d expected %0d actual %0d",
			frame_name(0), $sampled(out_cnt), $sampled(const_ref), $sampled(pxl_out)));

endmodule

`default_nettype wire

/* sources.f */
pool_pkg.sv
pool_frame_ctrl.sv
pool_line_buffer.sv
pool_window.sv
pool_avg_core.sv
pool_out_fifo.sv
avgp_3x3_top.sv
tb_avgp_3x3.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run the testbench, judge the result from the log

LOG=sim.log
BUILD_LOG=build.log
BIN=tb_avgp_3x3_sim

cd "$(dirname "$0")" || exit 1
rm -f "$LOG" "$BUILD_LOG"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_avgp_3x3 -o "$BIN" -f sources.f > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "Verilator build failed"; exit 1; }

./obj_dir/"$BIN" > "$LOG" 2>&1 || true
cat "$LOG"

grep -q "Test FAILED" "$LOG" && { echo "Simulation reported a failure"; exit 1; }
grep -q "Test OK" "$LOG" || { echo "No pass message found in $LOG"; exit 1; }
echo "Simulation passed"
